/* flist.f */
+incdir+logic
logic/graph_pkg.sv
logic/cu_port_if.sv
logic/fifo.sv
logic/rr_arbiter_n_to_1.sv
logic/rr_arbiter_1_to_n.sv
logic/cu_vertex_accumulate.sv
logic/cu_graph_algorithm_control.sv
test/cu_graph_tb.sv

/* Bender.yml */
package:
  name: cu_graph

sources:
  - include_dirs:
      - logic
    files:
      - logic/graph_pkg.sv
      - logic/cu_port_if.sv
      - logic/fifo.sv
      - logic/rr_arbiter_n_to_1.sv
      - logic/rr_arbiter_1_to_n.sv
      - logic/cu_vertex_accumulate.sv
      - logic/cu_graph_algorithm_control.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/cu_graph_tb.sv

/* test/cu_graph_tb.sv */
`include "graph_defs.svh"

module cu_graph_tb;
	import graph_pkg::*;

	localparam int NUM_CU       = `NUM_VERTEX_CU;
	localparam int SEND_TIMEOUT = 1000;
	localparam int DONE_TIMEOUT = 4000;

	// One memory answer waiting for its delay to run out
	typedef struct packed {
		response_t resp;
		int        due;
	} pending_t;

	logic                       clock;
	logic                       rstn;
	logic                       enabled;
	vertex_job_t                vertex_job;
	buffer_status_t             vertex_buffer_status;
	buffer_status_t             read_buffer_status;
	buffer_status_t             write_buffer_status;
	response_t                  read_response_in;
	response_t                  write_response_in;
	command_t                   read_command_out;
	command_t                   write_command_out;
	logic                       vertex_job_request;
	logic [`VERTEX_ID_BITS-1:0] vertex_job_counter_done;

	// Scoreboard
	vertex_job_t                sent_jobs [int];
	// CU that issued the read of each vertex
	logic [`CU_ID_BITS-1:0]     read_cu [int];
	bit                         write_seen [int];
	pending_t                   read_pending [$];
	pending_t                   write_pending [$];
	logic [NUM_CU-1:0]          cu_seen = '0;
	logic [`VERTEX_ID_BITS-1:0] test_reads = '0;
	logic [`VERTEX_ID_BITS-1:0] test_writes = '0;
	int                         total_sent = 0;

	// Run state
	logic [31:0]                lcg_state = 32'hd4beee86;
	int                         cycle = 0;
	int                         pause_end = 0;
	int                         errors = 0;
	int                         checks = 0;
	int                         tests_run = 0;
	int                         test_errors_start = 0;
	logic                       timed_out = 1'b0;
	int                         read_alfull_run = 0;
	int                         write_alfull_run = 0;
	int                         disabled_run = 0;
	logic [`VERTEX_ID_BITS-1:0] held_done = '0;

	cu_graph_algorithm_control cu_graph_algorithm_control_i (
		.clock                  (clock),
		.rstn                   (rstn),
		.enabled                (enabled),
		.vertex_job             (vertex_job),
		.vertex_buffer_status   (vertex_buffer_status),
		.read_buffer_status     (read_buffer_status),
		.write_buffer_status    (write_buffer_status),
		.read_response_in       (read_response_in),
		.write_response_in      (write_response_in),
		.read_command_out       (read_command_out),
		.write_command_out      (write_command_out),
		.vertex_job_request     (vertex_job_request),
		.vertex_job_counter_done(vertex_job_counter_done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Fixed contents of the vertex value area
	function automatic logic [`DATA_BITS-1:0] mem_value(input logic [`ADDR_BITS-1:0] address);
		logic [31:0] x;
		x = address ^ 32'h5a5a_1234;
		x = x * 32'h045d_9f3b;
		return x ^ (x >> 15);
	endfunction

	// Expected read or write for one job
	function automatic command_t expected_command(input vertex_job_t job, input logic is_write);
		command_t cmd;
		cmd          = '0;
		cmd.valid    = 1'b1;
		cmd.is_write = is_write;
		if (is_write) begin
			cmd.address = `RESULT_BASE + `ADDR_BITS'(job.vertex_id);
			cmd.data    = mem_value(`ADDR_BITS'(job.vertex_id)) + `DATA_BITS'(job.weight);
		end else begin
			cmd.address = `ADDR_BITS'(job.vertex_id);
		end
		return cmd;
	endfunction

	// Fresh vertex id not yet used in this run
	function automatic vertex_job_t new_job();
		vertex_job_t job;
		job.valid = 1'b1;
		do begin
			job.vertex_id = `VERTEX_ID_BITS'(lcg_next() >> 12);
		end while (sent_jobs.exists(int'(job.vertex_id)));
		job.weight = `WEIGHT_BITS'(lcg_next() >> 8);
		return job;
	endfunction

	task automatic check_command(input string name, input command_t got, input command_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [`VERTEX_ID_BITS-1:0] got,
			input logic [`VERTEX_ID_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t while waiting for %s", $time, what);
		timed_out = 1'b1;
		wait (1'b0);
	endtask

	initial begin
		wait (timed_out);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////

	// Oldest answer whose delay has run out
	task automatic pop_due(ref pending_t queue[$], output response_t resp);
		int pick;
		pick = -1;
		for (int i = 0; i < queue.size(); i++) begin
			if (pick < 0 && queue[i].due <= cycle) begin
				pick = i;
			end
		end
		resp = '0;
		if (pick >= 0) begin
			resp = queue[pick].resp;
			queue.delete(pick);
		end
	endtask

	task automatic observe_read(input command_t cmd);
		command_t exp;
		pending_t entry;
		int       vid;
		vid = int'(cmd.address);
		cu_seen[cmd.cu_id] = 1'b1;
		test_reads++;
		if (!sent_jobs.exists(vid) || read_cu.exists(vid)) begin
			errors++;
			$display("Unexpected or repeated read of address %h at time %0t", cmd.address, $time);
		end else begin
			read_cu[vid] = cmd.cu_id;
			exp          = expected_command(sent_jobs[vid], 1'b0);
			// Any CU may serve the job
			exp.cu_id    = cmd.cu_id;
			check_command("read_command_out", cmd, exp);
		end
		entry.resp = '{valid: 1'b1, cu_id: cmd.cu_id, data: mem_value(cmd.address)};
		entry.due  = cycle + 1 + int'((lcg_next() >> 16) % 6);
		read_pending.push_back(entry);
	endtask

	task automatic observe_write(input command_t cmd);
		command_t exp;
		pending_t entry;
		int       vid;
		vid = int'(cmd.address - `RESULT_BASE);
		cu_seen[cmd.cu_id] = 1'b1;
		test_writes++;
		if (!read_cu.exists(vid) || write_seen.exists(vid)) begin
			errors++;
			$display("Unexpected or repeated write to address %h at time %0t", cmd.address, $time);
		end else begin
			write_seen[vid] = 1'b1;
			exp             = expected_command(sent_jobs[vid], 1'b1);
			// The CU that read the vertex also writes its result
			exp.cu_id       = read_cu[vid];
			check_command("write_command_out", cmd, exp);
		end
		entry.resp = '{valid: 1'b1, cu_id: cmd.cu_id, data: '0};
		entry.due  = cycle + 1 + int'((lcg_next() >> 16) % 6);
		write_pending.push_back(entry);
	endtask

	// Memory answers and the enable line
	// Nothing is answered while paused
	initial begin
		enabled           = 1'b1;
		read_response_in  = '0;
		write_response_in = '0;
		forever begin
			@(posedge clock);
			#1;
			enabled           = (cycle >= pause_end);
			read_response_in  = '0;
			write_response_in = '0;
			if (enabled) begin
				pop_due(read_pending, read_response_in);
				pop_due(write_pending, write_response_in);
			end
		end
	end

	// Outputs are sampled mid-cycle
	always @(negedge clock) begin
		if (rstn) begin
			if (read_command_out.valid) begin
				observe_read(read_command_out);
			end
			if (write_command_out.valid) begin
				observe_write(write_command_out);
			end
			read_alfull_run  = read_buffer_status.alfull ? read_alfull_run + 1 : 0;
			write_alfull_run = write_buffer_status.alfull ? write_alfull_run + 1 : 0;
			disabled_run     = enabled ? 0 : disabled_run + 1;
			// Arbiter and output register have drained by now
			if (read_alfull_run >= 3) begin
				check_flag("read_command_out.valid", read_command_out.valid, 1'b0);
			end
			if (write_alfull_run >= 3) begin
				check_flag("write_command_out.valid", write_command_out.valid, 1'b0);
			end
			if (disabled_run >= 2) begin
				check_count("vertex_job_counter_done", vertex_job_counter_done, held_done);
			end
			if (disabled_run >= 3) begin
				check_flag("read_command_out.valid", read_command_out.valid, 1'b0);
				check_flag("write_command_out.valid", write_command_out.valid, 1'b0);
			end
			held_done = vertex_job_counter_done;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Offers jobs every cycle that the DUT asks for one
	task automatic send_jobs(input int n, output logic request_fell);
		int          sent;
		int          idle;
		logic        was_high;
		vertex_job_t job;
		sent         = 0;
		idle         = 0;
		was_high     = 1'b0;
		request_fell = 1'b0;
		@(posedge clock);
		#1;
		vertex_buffer_status.empty = 1'b0;
		while (sent < n) begin
			@(posedge clock);
			#1;
			if (vertex_job_request) begin
				job = new_job();
				sent_jobs[int'(job.vertex_id)] = job;
				vertex_job = job;
				sent++;
				total_sent++;
				idle     = 0;
				was_high = 1'b1;
			end else begin
				vertex_job = '0;
				if (was_high) begin
					request_fell = 1'b1;
				end
				idle++;
				if (idle > SEND_TIMEOUT) begin
					report_timeout("vertex_job_request");
				end
			end
		end
		@(posedge clock);
		#1;
		vertex_job                 = '0;
		vertex_buffer_status.empty = 1'b1;
	endtask

	task automatic hold_alfull(input logic on_write);
		repeat (4) @(posedge clock);
		#1;
		if (on_write) begin
			write_buffer_status.alfull = 1'b1;
		end else begin
			read_buffer_status.alfull = 1'b1;
		end
		repeat (20) @(posedge clock);
		#1;
		write_buffer_status.alfull = 1'b0;
		read_buffer_status.alfull  = 1'b0;
	endtask

	// Waits for all jobs so far, then makes sure nothing extra completes
	task automatic wait_done(input int jobs_in_test);
		int waited;
		waited = 0;
		while (vertex_job_counter_done != `VERTEX_ID_BITS'(total_sent)) begin
			@(negedge clock);
			waited++;
			if (waited > DONE_TIMEOUT) begin
				report_timeout("vertex_job_counter_done");
			end
		end
		repeat (10) @(negedge clock);
		check_count("vertex_job_counter_done", vertex_job_counter_done, total_sent);
		check_count("read command count", test_reads, jobs_in_test);
		check_count("write command count", test_writes, jobs_in_test);
	endtask

	task automatic begin_test();
		test_errors_start = errors;
		test_reads        = '0;
		test_writes       = '0;
		cu_seen           = '0;
	endtask

	task automatic end_test(input int id, input string name);
		tests_run++;
		if (errors == test_errors_start) begin
			$display("Test %0d %s: ok", id, name);
		end else begin
			$display("Test %0d %s: %0d errors", id, name, errors - test_errors_start);
		end
	endtask

	initial begin
		logic fell;
		rstn                 = 1'b0;
		vertex_job           = '0;
		vertex_buffer_status = '{valid: 1'b1, empty: 1'b1, alfull: 1'b0, full: 1'b0};
		read_buffer_status   = '{valid: 1'b1, empty: 1'b1, alfull: 1'b0, full: 1'b0};
		write_buffer_status  = '{valid: 1'b1, empty: 1'b1, alfull: 1'b0, full: 1'b0};
		repeat (5) @(posedge clock);
		#1;
		rstn = 1'b1;

		begin_test();
		@(negedge clock);
		check_command("read_command_out", read_command_out, '0);
		check_command("write_command_out", write_command_out, '0);
		check_flag("vertex_job_request", vertex_job_request, 1'b0);
		check_count("vertex_job_counter_done", vertex_job_counter_done, '0);
		send_jobs(1, fell);
		wait_done(1);
		end_test(1, "reset and single job");

		begin_test();
		send_jobs(40, fell);
		wait_done(40);
		check_flag("all cu_id values seen", &cu_seen, 1'b1);
		end_test(2, "forty random jobs");

		begin_test();
		fork
			send_jobs(12, fell);
			hold_alfull(1'b0);
		join
		wait_done(12);
		end_test(3, "read port alfull");

		begin_test();
		fork
			send_jobs(12, fell);
			hold_alfull(1'b1);
		join
		wait_done(12);
		end_test(4, "write port alfull");

		begin_test();
		send_jobs(24, fell);
		check_flag("vertex_job_request fell", fell, 1'b1);
		wait_done(24);
		end_test(5, "job back-pressure");

		begin_test();
		send_jobs(16, fell);
		@(negedge clock);
		check_flag("jobs in flight at pause",
			vertex_job_counter_done != `VERTEX_ID_BITS'(total_sent), 1'b1);
		pause_end = cycle + 16;
		repeat (20) @(negedge clock);
		wait_done(16);
		end_test(6, "enable pause");

		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* logic/cu_graph_algorithm_control.sv */
`include "graph_defs.svh"

module cu_graph_algorithm_control #(
	parameter int NUM_VERTEX_CU = `NUM_VERTEX_CU
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  graph_pkg::vertex_job_t     vertex_job,
	input  graph_pkg::buffer_status_t  vertex_buffer_status,
	input  graph_pkg::buffer_status_t  read_buffer_status,
	input  graph_pkg::buffer_status_t  write_buffer_status,
	input  graph_pkg::response_t       read_response_in,
	input  graph_pkg::response_t       write_response_in,
	output graph_pkg::command_t        read_command_out,
	output graph_pkg::command_t        write_command_out,
	output logic                       vertex_job_request,
	output logic [`VERTEX_ID_BITS-1:0] vertex_job_counter_done
);
	import graph_pkg::*;

	// Registered inputs
	vertex_job_t    vertex_job_latched;
	response_t      read_response_latched;
	response_t      write_response_latched;

	// Job buffer
	buffer_status_t job_buffer_status;
	vertex_job_t    job_head;
	logic           job_pop;

	// Per-CU traffic
	vertex_job_t                job_cu [NUM_VERTEX_CU];
	logic [NUM_VERTEX_CU-1:0]   job_request_cu;
	command_t                   read_head_cu [NUM_VERTEX_CU];
	command_t                   write_head_cu [NUM_VERTEX_CU];
	logic [NUM_VERTEX_CU-1:0]   read_request_cu;
	logic [NUM_VERTEX_CU-1:0]   read_ready_cu;
	logic [NUM_VERTEX_CU-1:0]   write_request_cu;
	logic [NUM_VERTEX_CU-1:0]   write_ready_cu;
	response_t                  read_steer [NUM_VERTEX_CU];
	response_t                  write_steer [NUM_VERTEX_CU];
	response_t                  read_response_cu [NUM_VERTEX_CU];
	response_t                  write_response_cu [NUM_VERTEX_CU];
	logic [`VERTEX_ID_BITS-1:0] completed_cu [NUM_VERTEX_CU];
	logic [`VERTEX_ID_BITS-1:0] completed_sum;

	// Arbiter results before the output registers
	command_t read_command_arb;
	command_t write_command_arb;

	cu_port_if cu_port [NUM_VERTEX_CU] ();

	////////////////////////////////////////////////////////////
	// Input and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_latched     <= '0;
			read_response_latched  <= '0;
			write_response_latched <= '0;
		end else if (enabled) begin
			vertex_job_latched     <= vertex_job;
			read_response_latched  <= read_response_in;
			write_response_latched <= write_response_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out   <= '0;
			write_command_out  <= '0;
			vertex_job_request <= 1'b0;
		end else begin
			read_command_out   <= read_command_arb;
			write_command_out  <= write_command_arb;
			// Margin in the job FIFO covers jobs already on their way in
			vertex_job_request <= enabled && !vertex_buffer_status.empty &&
				!job_buffer_status.alfull;
		end
	end

	////////////////////////////////////////////////////////////
	// Job buffer and dispatch to the CUs
	////////////////////////////////////////////////////////////

	fifo #(
		.payload_t(vertex_job_t),
		.DEPTH    (`JOB_FIFO_DEPTH)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job_latched.valid && enabled),
		.data_in (vertex_job_latched),
		.pop     (job_pop),
		.data_out(job_head),
		.valid   (job_buffer_status.valid),
		.empty   (job_buffer_status.empty),
		.alfull  (job_buffer_status.alfull),
		.full    (job_buffer_status.full)
	);

	rr_arbiter_1_to_n #(
		.NUM_REQUESTS(NUM_VERTEX_CU),
		.payload_t   (vertex_job_t)
	) job_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.buffer_in   (job_head),
		.buffer_empty(job_buffer_status.empty),
		.requests    (job_request_cu),
		.arbiter_out (job_cu),
		.ready       (job_pop)
	);

	////////////////////////////////////////////////////////////
	// Response steering by cu_id
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			read_steer[i]  = '0;
			write_steer[i] = '0;
			if (read_response_latched.valid && read_response_latched.cu_id == `CU_ID_BITS'(i)) begin
				read_steer[i] = read_response_latched;
			end
			if (write_response_latched.valid &&
				write_response_latched.cu_id == `CU_ID_BITS'(i)) begin
				write_steer[i] = write_response_latched;
			end
		end
	end

	// Held while disabled so a waiting CU still sees its answer
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_cu  <= '{default: '0};
			write_response_cu <= '{default: '0};
		end else if (enabled) begin
			read_response_cu  <= read_steer;
			write_response_cu <= write_steer;
		end
	end

	////////////////////////////////////////////////////////////
	// Compute units and their command FIFOs
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_VERTEX_CU; i++) begin : gen_cu
		assign cu_port[i].job            = job_cu[i];
		assign cu_port[i].read_response  = read_response_cu[i];
		assign cu_port[i].write_response = write_response_cu[i];
		assign job_request_cu[i]         = cu_port[i].job_request;

		// Port alfull stops all CUs at once
		assign read_request_cu[i]  = !cu_port[i].read_status.empty && !read_buffer_status.alfull;
		assign write_request_cu[i] = !cu_port[i].write_status.empty && !write_buffer_status.alfull;

		fifo #(
			.payload_t(command_t),
			.DEPTH    (`CMD_FIFO_DEPTH)
		) read_command_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (cu_port[i].read_command.valid),
			.data_in (cu_port[i].read_command),
			.pop     (read_ready_cu[i]),
			.data_out(read_head_cu[i]),
			.valid   (cu_port[i].read_status.valid),
			.empty   (cu_port[i].read_status.empty),
			.alfull  (cu_port[i].read_status.alfull),
			.full    (cu_port[i].read_status.full)
		);

		fifo #(
			.payload_t(command_t),
			.DEPTH    (`CMD_FIFO_DEPTH)
		) write_command_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (cu_port[i].write_command.valid),
			.data_in (cu_port[i].write_command),
			.pop     (write_ready_cu[i]),
			.data_out(write_head_cu[i]),
			.valid   (cu_port[i].write_status.valid),
			.empty   (cu_port[i].write_status.empty),
			.alfull  (cu_port[i].write_status.alfull),
			.full    (cu_port[i].write_status.full)
		);

		cu_vertex_accumulate #(
			.CU_ID(i)
		) cu (
			.clock    (clock),
			.rstn     (rstn),
			.enabled  (enabled),
			.port     (cu_port[i].cu),
			.completed(completed_cu[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Command merge onto the memory ports
	////////////////////////////////////////////////////////////

	rr_arbiter_n_to_1 #(
		.NUM_REQUESTS(NUM_VERTEX_CU),
		.payload_t   (command_t)
	) read_command_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.requests   (read_request_cu),
		.buffer_in  (read_head_cu),
		.arbiter_out(read_command_arb),
		.ready      (read_ready_cu)
	);

	rr_arbiter_n_to_1 #(
		.NUM_REQUESTS(NUM_VERTEX_CU),
		.payload_t   (command_t)
	) write_command_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.requests   (write_request_cu),
		.buffer_in  (write_head_cu),
		.arbiter_out(write_command_arb),
		.ready      (write_ready_cu)
	);

	// Done count is the total over all units
	always_comb begin
		completed_sum = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			completed_sum = completed_sum + completed_cu[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_counter_done <= '0;
		end else if (enabled) begin
			vertex_job_counter_done <= completed_sum;
		end
	end

	// Arbiter plus output register drain within two cycles of alfull
	assert property (@(posedge clock) disable iff (!rstn)
		$past(read_buffer_status.alfull, 2) && $past(read_buffer_status.alfull)
		|-> !read_command_out.valid)
		else $error("read command issued under alfull");
	assert property (@(posedge clock) disable iff (!rstn)
		$past(write_buffer_status.alfull, 2) && $past(write_buffer_status.alfull)
		|-> !write_command_out.valid)
		else $error("write command issued under alfull");

endmodule

/* logic/cu_vertex_accumulate.sv */
`include "graph_defs.svh"

module cu_vertex_accumulate #(
	parameter int CU_ID = 0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	cu_port_if.cu                      port,
	output logic [`VERTEX_ID_BITS-1:0] completed
);
	import graph_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_READ_WAIT,
		S_WRITE,
		S_WRITE_WAIT
	} state_t;

	state_t                     state;
	command_t                   read_command_q;
	command_t                   write_command_q;
	logic [`VERTEX_ID_BITS-1:0] vertex_id;
	logic [`WEIGHT_BITS-1:0]    weight;
	logic [`DATA_BITS-1:0]      sum;
	logic                       take_job;
	logic                       take_read;

	assign port.job_request  = (state == S_IDLE);
	assign port.read_command  = read_command_q;
	assign port.write_command = write_command_q;

	assign take_job  = enabled && (state == S_IDLE) && port.job.valid;
	assign take_read = enabled && (state == S_READ_WAIT) && port.read_response.valid;

	// Job fields and the accumulated value
	always_ff @(posedge clock) begin
		if (take_job) begin
			vertex_id <= port.job.vertex_id;
			weight    <= port.job.weight;
		end
		if (take_read) begin
			sum <= port.read_response.data + `DATA_BITS'(weight);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state           <= S_IDLE;
			read_command_q  <= '0;
			write_command_q <= '0;
			completed       <= '0;
		end else begin
			// Commands are one-cycle pushes into this CU's FIFOs
			read_command_q  <= '0;
			write_command_q <= '0;
			if (enabled) begin
				case (state)
					S_IDLE: begin
						if (port.job.valid) begin
							state <= S_READ;
						end
					end
					S_READ: begin
						if (!port.read_status.alfull) begin
							read_command_q <= '{valid: 1'b1, is_write: 1'b0,
								cu_id: `CU_ID_BITS'(CU_ID),
								address: `ADDR_BITS'(vertex_id), data: '0};
							state <= S_READ_WAIT;
						end
					end
					S_READ_WAIT: begin
						if (port.read_response.valid) begin
							state <= S_WRITE;
						end
					end
					S_WRITE: begin
						if (!port.write_status.alfull) begin
							write_command_q <= '{valid: 1'b1, is_write: 1'b1,
								cu_id: `CU_ID_BITS'(CU_ID),
								address: `RESULT_BASE + `ADDR_BITS'(vertex_id), data: sum};
							state <= S_WRITE_WAIT;
						end
					end
					S_WRITE_WAIT: begin
						if (port.write_response.valid) begin
							completed <= completed + 1'b1;
							state     <= S_IDLE;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// Steering must only deliver what this unit asked for
	assert property (@(posedge clock) disable iff (!rstn)
		port.read_response.valid |-> state == S_READ_WAIT)
		else $error("cu %0d: unexpected read response", CU_ID);
	assert property (@(posedge clock) disable iff (!rstn)
		port.write_response.valid |-> state == S_WRITE_WAIT)
		else $error("cu %0d: unexpected write response", CU_ID);

endmodule

/* logic/rr_arbiter_1_to_n.sv */
module rr_arbiter_1_to_n #(
	parameter int  NUM_REQUESTS = 4,
	parameter type payload_t    = logic
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  payload_t                buffer_in,
	input  logic                    buffer_empty,
	input  logic [NUM_REQUESTS-1:0] requests,
	output payload_t                arbiter_out [NUM_REQUESTS],
	output logic                    ready
);
	import graph_pkg::*;

	localparam int PTR_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [PTR_BITS-1:0] pointer;
	int                  pick;

	// Nothing is handed out without a head entry
	always_comb begin
		if (enabled && !buffer_empty) begin
			pick = rr_pick(32'(requests), int'(pointer), NUM_REQUESTS);
		end else begin
			pick = -1;
		end
	end

	assign ready = (pick >= 0);

	// Only the chosen requester sees a valid payload
	always_comb begin
		for (int i = 0; i < NUM_REQUESTS; i++) begin
			arbiter_out[i] = (pick == i) ? buffer_in : '0;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer <= '0;
		end else if (ready) begin
			if (pick == NUM_REQUESTS - 1) begin
				pointer <= '0;
			end else begin
				pointer <= PTR_BITS'(pick + 1);
			end
		end
	end

endmodule

/* logic/rr_arbiter_n_to_1.sv */
module rr_arbiter_n_to_1 #(
	parameter int  NUM_REQUESTS = 4,
	parameter type payload_t    = logic
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic [NUM_REQUESTS-1:0] requests,
	input  payload_t                buffer_in [NUM_REQUESTS],
	output payload_t                arbiter_out,
	output logic [NUM_REQUESTS-1:0] ready
);
	import graph_pkg::*;

	localparam int PTR_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [PTR_BITS-1:0] pointer;
	int                  pick;
	logic                grant;

	// Search begins at the pointer so every source gets a turn
	always_comb begin
		pick = rr_pick(32'(requests), int'(pointer), NUM_REQUESTS);
	end

	assign grant = enabled && (pick >= 0);

	// One-hot pop back to the granted FIFO
	always_comb begin
		ready = '0;
		if (grant) begin
			ready[pick] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer     <= '0;
			arbiter_out <= '0;
		end else if (grant) begin
			arbiter_out <= buffer_in[pick];
			// Granted source moves to lowest priority
			if (pick == NUM_REQUESTS - 1) begin
				pointer <= '0;
			end else begin
				pointer <= PTR_BITS'(pick + 1);
			end
		end else begin
			// Empty slot while the pointer keeps its place
			arbiter_out <= '0;
		end
	end

endmodule

/* logic/fifo.sv */
`include "graph_defs.svh"

module fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     valid,
	output logic     empty,
	output logic     alfull,
	output logic     full
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	payload_t              mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Status flags
	assign empty  = (count == '0);
	assign full   = (count == COUNT_BITS'(DEPTH));
	assign alfull = (count >= COUNT_BITS'(DEPTH - `FIFO_ALFULL_MARGIN));
	assign valid  = !empty;

	// Head is visible without a pop
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Writers must watch alfull, readers must watch empty
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("fifo: push while full");
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("fifo: pop while empty");

endmodule

/* logic/cu_port_if.sv */
// All signals between the controller and one compute unit
interface cu_port_if;
	import graph_pkg::*;

	// Controller to CU
	vertex_job_t    job;
	response_t      read_response;
	response_t      write_response;
	buffer_status_t read_status;
	buffer_status_t write_status;

	// CU to controller
	logic           job_request;
	command_t       read_command;
	command_t       write_command;

	modport ctrl (
		output job,
		output read_response,
		output write_response,
		output read_status,
		output write_status,
		input  job_request,
		input  read_command,
		input  write_command
	);

	modport cu (
		input  job,
		input  read_response,
		input  write_response,
		input  read_status,
		input  write_status,
		output job_request,
		output read_command,
		output write_command
	);

endinterface

/* logic/graph_pkg.sv */
`include "graph_defs.svh"

package graph_pkg;

	// One 33-bit vertex job from the job stream
	typedef struct packed {
		logic                       valid;
		logic [`VERTEX_ID_BITS-1:0] vertex_id;
		logic [`WEIGHT_BITS-1:0]    weight;
	} vertex_job_t;

	// Read or write request toward memory
	typedef struct packed {
		logic                   valid;
		logic                   is_write;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`ADDR_BITS-1:0]  address;
		logic [`DATA_BITS-1:0]  data;
	} command_t;

	// Memory answer tagged with the issuing CU
	typedef struct packed {
		logic                   valid;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`DATA_BITS-1:0]  data;
	} response_t;

	typedef struct packed {
		logic valid;
		logic empty;
		logic alfull;
		logic full;
	} buffer_status_t;

	// Round-robin pick shared by both arbiters
	// Returns the first set request at or after pointer, or -1 when none
	function automatic int rr_pick(input logic [31:0] requests, input int pointer, input int n);
		int idx;
		rr_pick = -1;
		for (int k = n - 1; k >= 0; k--) begin
			idx = pointer + k;
			if (idx >= n) begin
				idx = idx - n;
			end
			if (requests[idx]) begin
				rr_pick = idx;
			end
		end
	endfunction

endpackage

/* logic/graph_defs.svh */
`ifndef GRAPH_DEFS_SVH
`define GRAPH_DEFS_SVH

// Compute units and the tag that routes responses back to them
`define NUM_VERTEX_CU 4
`define CU_ID_BITS 2

// Field widths
`define VERTEX_ID_BITS 16
`define WEIGHT_BITS 16
`define DATA_BITS 32
`define ADDR_BITS 32

// Buffer sizing
`define JOB_FIFO_DEPTH 8
`define CMD_FIFO_DEPTH 4
`define FIFO_ALFULL_MARGIN 2

// Results land above the vertex value area
`define RESULT_BASE 32'h0001_0000

`endif
